// ==== Makefile ====
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = fma16Tb
FILELIST = sim.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG) || ! grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "Simulation reported a failure"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== hdl/alignAdder.sv ====
`timescale 1ns/100ps
//======================================
// Aligns the product and C, then adds
// or subtracts the significands
//======================================
module alignAdder (
    input  logic            productSign,
    input  fmaPkg::wideExpT productExp,
    input  fmaPkg::prodT    productSig,
    input  logic            productNegative,
    input  logic            productZero,
    input  logic            productOperandInf,
    input  logic            signC,
    input  fmaPkg::expT     expC,
    input  fmaPkg::sigT     sigC,
    output logic            signMismatch,
    output logic            stickyA,
    output logic            stickyB,
    output logic            sumSign,
    output fmaPkg::expT     sumExp,
    output fmaPkg::sumT     sumSig
);
    import fmaPkg::*;

    // Guard field below the product LSB that catches shifted bits
    localparam int guardBits  = 20;
    localparam int alignWidth = prodWidth + guardBits;

    wideExpT               expDiff;
    wideExpT               shiftA, shiftB;
    logic                  cGreater;
    logic [alignWidth-1:0] extA, extB;
    logic [alignWidth-1:0] alignedA, alignedB;
    logic [alignWidth-1:0] lostMaskA, lostMaskB;
    sumT                   addA, addB;
    sumT                   stdSum, revSum;
    logic                  useRev;

    assign expDiff  = productExp - {1'b0, expC};
    // A zero or underflowed product never sets the exponent
    assign cGreater = expDiff[expWidth] | productNegative | productZero;
    assign shiftA   = cGreater ? -expDiff : '0;
    assign shiftB   = cGreater ? '0 : expDiff;

    // C sits one bit lower so both hold 1.0 at the same weight
    assign extA     = {productSig, {guardBits{1'b0}}};
    assign extB     = {1'b0, sigC, {(alignWidth-sigWidth-1){1'b0}}};
    assign alignedA = extA >> shiftA;
    assign alignedB = extB >> shiftB;

    // Bits pushed past the guard field are gone but still count as sticky
    assign lostMaskA = ~({alignWidth{1'b1}} << shiftA);
    assign lostMaskB = ~({alignWidth{1'b1}} << shiftB);
    assign stickyA   = (|alignedA[guardBits-1:0]) | (|(extA & lostMaskA));
    assign stickyB   = (|alignedB[guardBits-1:0]) | (|(extB & lostMaskB));

    assign signMismatch = productSign ^ signC;
    assign addA = {1'b0, alignedA[alignWidth-1:guardBits], stickyA};
    assign addB = {1'b0, alignedB[alignWidth-1:guardBits], stickyB};

    // Carry into the top bit on subtraction is discarded by the normalizer
    assign stdSum = addA + (signMismatch ? {1'b0, ~addB[sumWidth-2:0]} : addB)
                  + sumT'(signMismatch);
    assign revSum = addB - addA;

    // C dominates, so take C minus product to keep the magnitude positive
    assign useRev  = signMismatch & ~revSum[sumWidth-1];
    assign sumSig  = useRev ? revSum : stdSum;
    assign sumSign = productSign ^ (useRev & ~productOperandInf);
    assign sumExp  = cGreater ? expC : productExp[expWidth-1:0];

endmodule

// ==== hdl/fma16.sv ====
`timescale 1ns/100ps
//======================================
// Half-precision FMA top, A * B + C
// with one registered output stage
//======================================
module fma16 (
    input  logic              clk,
    input  logic              rstN,
    input  fmaPkg::halfT      operandA,
    input  fmaPkg::halfT      operandB,
    input  fmaPkg::halfT      operandC,
    input  logic              mul,
    input  logic              add,
    input  fmaPkg::roundModeT roundMode,
    output fmaPkg::halfT      result,
    output logic [3:0]        flags
);
    import fmaPkg::*;

    // Effective operand fields
    logic                 signA, signB, signC;
    expT                  expA, expB, expC;
    sigT                  sigA, sigB, sigC;
    logic                 productZero;
    logic                 productOperandInf;

    // Product stage
    logic                 productSign;
    wideExpT              productExp;
    prodT                 productSig;
    logic                 productOverflow;
    logic                 productNegative;

    // Accumulate stage
    logic                 signMismatch;
    logic                 stickyA, stickyB;
    logic                 sumSign;
    expT                  sumExp;
    sumT                  sumSig;

    // Normalize and round
    sumT                  normSig;
    expT                  normExp;
    logic                 normOverflow;
    expT                  roundedExp;
    logic [fracWidth-1:0] roundedFrac;
    logic                 inexactRound;

    fmaControl u_control (
        .clk, .rstN, .operandA, .operandB, .operandC, .mul, .add, .roundMode,
        .productSign, .productOverflow, .sumSign, .signMismatch, .normOverflow,
        .roundedExp, .roundedFrac, .inexactRound,
        .signA, .signB, .signC, .expA, .expB, .expC, .sigA, .sigB, .sigC,
        .productZero, .productOperandInf, .result, .flags
    );

    productUnit u_product (
        .signA, .signB, .expA, .expB, .sigA, .sigB, .productZero,
        .productSign, .productExp, .productSig, .productOverflow, .productNegative
    );

    alignAdder u_align (
        .productSign, .productExp, .productSig, .productNegative, .productZero,
        .productOperandInf, .signC, .expC, .sigC,
        .signMismatch, .stickyA, .stickyB, .sumSign, .sumExp, .sumSig
    );

    normalizer u_norm (
        .sumSig, .sumExp, .signMismatch, .normSig, .normExp, .normOverflow
    );

    rounder u_round (
        .roundMode, .normExp, .normSig, .stickyA, .stickyB,
        .preRoundOverflow(productOverflow | normOverflow),
        .roundedExp, .roundedFrac, .inexactRound
    );

endmodule

// ==== hdl/fmaControl.sv ====
`timescale 1ns/100ps
//======================================
// FMA control: operand decode, special
// cases, flags and the output register
//======================================
module fmaControl (
    input  logic                         clk,
    input  logic                         rstN,
    input  fmaPkg::halfT                 operandA,
    input  fmaPkg::halfT                 operandB,
    input  fmaPkg::halfT                 operandC,
    input  logic                         mul,
    input  logic                         add,
    input  fmaPkg::roundModeT            roundMode,
    input  logic                         productSign,
    input  logic                         productOverflow,
    input  logic                         sumSign,
    input  logic                         signMismatch,
    input  logic                         normOverflow,
    input  fmaPkg::expT                  roundedExp,
    input  logic [fmaPkg::fracWidth-1:0] roundedFrac,
    input  logic                         inexactRound,
    output logic                         signA,
    output logic                         signB,
    output logic                         signC,
    output fmaPkg::expT                  expA,
    output fmaPkg::expT                  expB,
    output fmaPkg::expT                  expC,
    output fmaPkg::sigT                  sigA,
    output fmaPkg::sigT                  sigB,
    output fmaPkg::sigT                  sigC,
    output logic                         productZero,
    output logic                         productOperandInf,
    output fmaPkg::halfT                 result,
    output logic [3:0]                   flags
);
    import fmaPkg::*;

    // Stand-in for B when only an addition is requested
    localparam halfT oneWord = {1'b0, expWidth'(expBias), {fracWidth{1'b0}}};

    halfT                 effB, effC;
    logic [fracWidth-1:0] fracA, fracB, fracC;
    logic                 nanA, nanB, nanC;
    logic                 infA, infB, infC;
    logic                 zeroA, zeroB;
    logic                 invalidOp;
    logic                 arithSel;
    logic                 zeroSign;
    halfT                 nextResult;
    logic [3:0]           nextFlags;

    assign effB = mul ? operandB : oneWord;
    assign effC = add ? operandC : '0;

    assign signA = operandA[halfWidth-1];
    assign signB = effB[halfWidth-1];
    assign signC = effC[halfWidth-1];
    assign expA  = operandA[halfWidth-2 -: expWidth];
    assign expB  = effB[halfWidth-2 -: expWidth];
    assign expC  = effC[halfWidth-2 -: expWidth];
    assign fracA = operandA[fracWidth-1:0];
    assign fracB = effB[fracWidth-1:0];
    assign fracC = effC[fracWidth-1:0];

    // C only gets its hidden bit when it is nonzero
    assign sigA = {1'b1, fracA};
    assign sigB = {1'b1, fracB};
    assign sigC = {|effC[halfWidth-2:0], fracC};

    assign nanA  = (&expA) & (|fracA);
    assign nanB  = (&expB) & (|fracB);
    assign nanC  = (&expC) & (|fracC);
    assign infA  = (&expA) & ~(|fracA);
    assign infB  = (&expB) & ~(|fracB);
    assign infC  = (&expC) & ~(|fracC);
    assign zeroA = ~(|expA) & ~(|fracA);
    assign zeroB = ~(|expB) & ~(|fracB);

    assign productZero       = zeroA | zeroB;
    assign productOperandInf = infA | infB;

    // Exact zero: product sign alone, else -0 only for round toward negative
    assign zeroSign = ~add ? productSign : (signMismatch ? (roundMode == rn) : sumSign);

    always_comb begin
        invalidOp = 1'b0;
        arithSel  = 1'b0;
        if ((zeroA & infB) | (infA & zeroB)) begin
            nextResult = canonicalNaN;
            invalidOp  = 1'b1;
        end else if (nanA | nanB | nanC) begin
            nextResult = canonicalNaN;
        end else if (productOperandInf) begin
            // Infinite product meeting an opposite infinity
            if (infC & signMismatch) begin
                nextResult = canonicalNaN;
                invalidOp  = 1'b1;
            end else begin
                nextResult = {productSign, {expWidth{1'b1}}, {fracWidth{1'b0}}};
            end
        end else if (infC) begin
            nextResult = {signC, {expWidth{1'b1}}, {fracWidth{1'b0}}};
        end else begin
            arithSel = 1'b1;
            if (roundedExp == '0 && roundedFrac == '0) begin
                nextResult = {zeroSign, {(halfWidth-1){1'b0}}};
            end else begin
                nextResult = {sumSign, roundedExp, roundedFrac};
            end
        end
    end

    always_comb begin
        nextFlags = '0;
        // Signalling NaNs have the quiet bit clear
        nextFlags[flagInvalid]   = invalidOp | (nanA & ~fracA[fracWidth-1])
                                 | (nanB & ~fracB[fracWidth-1])
                                 | (nanC & ~fracC[fracWidth-1]);
        nextFlags[flagOverflow]  = arithSel & (productOverflow | normOverflow);
        nextFlags[flagUnderflow] = 1'b0;   // no subnormal support
        nextFlags[flagInexact]   = arithSel & (inexactRound | productOverflow | normOverflow);
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            result <= '0;
            flags  <= '0;
        end else begin
            result <= nextResult;
            flags  <= nextFlags;
        end
    end

endmodule

// ==== hdl/fmaPkg.sv ====
//======================================
// FMA package: binary16 field widths,
// constants, word types and round modes
//======================================
package fmaPkg;

    localparam int halfWidth = 16;
    localparam int expWidth  = 5;
    localparam int fracWidth = 10;
    localparam int sigWidth  = fracWidth + 1;
    localparam int prodWidth = 2 * sigWidth;
    // Product plus one carry bit and one sticky bit
    localparam int sumWidth  = prodWidth + 2;
    localparam int expBias   = 15;

    typedef logic [halfWidth-1:0] halfT;
    typedef logic [expWidth-1:0]  expT;
    typedef logic [expWidth:0]    wideExpT;
    typedef logic [sigWidth-1:0]  sigT;
    typedef logic [prodWidth-1:0] prodT;
    typedef logic [sumWidth-1:0]  sumT;

    typedef enum logic [1:0] {
        rz  = 2'd0,
        rne = 2'd1,
        rn  = 2'd2,
        rp  = 2'd3
    } roundModeT;

    // Quiet NaN returned for every NaN result
    localparam halfT canonicalNaN = 16'h7E00;
    // Largest finite magnitude, sign bit excluded
    localparam logic [halfWidth-2:0] maxFiniteMag = 15'h7BFF;

    // Bit positions inside the flags word
    localparam int flagInvalid   = 3;
    localparam int flagOverflow  = 2;
    localparam int flagUnderflow = 1;
    localparam int flagInexact   = 0;

endpackage

// ==== hdl/normalizer.sv ====
`timescale 1ns/100ps
//======================================
// Leading-one search, normalization
// shift and exponent adjustment
//======================================
module normalizer (
    input  fmaPkg::sumT sumSig,
    input  fmaPkg::expT sumExp,
    input  logic        signMismatch,
    output fmaPkg::sumT normSig,
    output fmaPkg::expT normExp,
    output logic        normOverflow
);
    import fmaPkg::*;

    // Sum bit that carries the weight 1.0
    localparam int leadRef = sumWidth - 3;

    logic                 carryOut;
    logic                 found;
    logic                 flush;
    logic [4:0]           leadPos, leadTop, shiftAmt;
    logic [expWidth+1:0]  adjExp;

    // Top bit is a real carry only for an effective addition
    assign carryOut = sumSig[sumWidth-1] & ~signMismatch;

    always_comb begin
        found   = 1'b0;
        leadPos = '0;
        for (int i = 0; i < sumWidth - 1; i++) begin
            if (sumSig[i]) begin
                found   = 1'b1;
                leadPos = 5'(i);
            end
        end
    end

    assign leadTop  = carryOut ? 5'(sumWidth - 1) : leadPos;
    // Leading one leaves through the top, fraction lands just below it
    assign shiftAmt = 5'(sumWidth - 1) - leadTop;
    assign adjExp   = {2'b0, sumExp} + {2'b0, leadTop} - 7'(leadRef);

    // Zero sums and exponents at or below zero flush to signed zero
    assign flush = ~(found | carryOut) | adjExp[expWidth+1] | (adjExp == '0);

    assign normOverflow = ~flush & (adjExp >= {2'b0, {expWidth{1'b1}}});
    assign normExp      = flush ? '0 : adjExp[expWidth-1:0];
    assign normSig      = flush ? '0 : sumSig << shiftAmt;

endmodule

// ==== hdl/productUnit.sv ====
`timescale 1ns/100ps
//======================================
// Product of A and B: sign, biased
// exponent sum and significand product
//======================================
module productUnit (
    input  logic            signA,
    input  logic            signB,
    input  fmaPkg::expT     expA,
    input  fmaPkg::expT     expB,
    input  fmaPkg::sigT     sigA,
    input  fmaPkg::sigT     sigB,
    input  logic            productZero,
    output logic            productSign,
    output fmaPkg::wideExpT productExp,
    output fmaPkg::prodT    productSig,
    output logic            productOverflow,
    output logic            productNegative
);
    import fmaPkg::*;

    wideExpT expSum;

    assign productSign = signA ^ signB;
    assign expSum      = {1'b0, expA} + {1'b0, expB};

    assign productExp  = productZero ? '0 : expSum - wideExpT'(expBias);
    assign productSig  = productZero ? '0 : sigA * sigB;

    // Top bit set after removing the bias: too large if the raw sum was
    // already past the field, wrapped below zero otherwise
    assign productOverflow = productExp[expWidth] & expSum[expWidth];
    assign productNegative = productExp[expWidth] & ~expSum[expWidth];

endmodule

// ==== hdl/rounder.sv ====
`timescale 1ns/100ps
//======================================
// Truncating rounder with inexact
// detection and overflow saturation
//======================================
module rounder (
    input  fmaPkg::roundModeT            roundMode,
    input  fmaPkg::expT                  normExp,
    input  fmaPkg::sumT                  normSig,
    input  logic                         stickyA,
    input  logic                         stickyB,
    input  logic                         preRoundOverflow,
    output fmaPkg::expT                  roundedExp,
    output logic [fmaPkg::fracWidth-1:0] roundedFrac,
    output logic                         inexactRound
);
    import fmaPkg::*;

    // Lowest kept fraction bit of the normalized sum
    localparam int fracLsb = sumWidth - 1 - fracWidth;

    logic guardBit, roundBit, stickyBit;

    assign guardBit  = normSig[fracLsb-1];
    assign roundBit  = normSig[fracLsb-2];
    assign stickyBit = |normSig[fracLsb-3:0];

    assign inexactRound = guardBit | roundBit | stickyBit | stickyA | stickyB;

    always_comb begin
        if (!preRoundOverflow) begin
            roundedExp  = normExp;
            roundedFrac = normSig[sumWidth-2:fracLsb];
        end else if (roundMode == rz) begin
            {roundedExp, roundedFrac} = maxFiniteMag;
        end else begin
            // All other modes overflow to infinity
            roundedExp  = '1;
            roundedFrac = '0;
        end
    end

endmodule

// ==== sim.f ====
hdl/fmaPkg.sv
hdl/productUnit.sv
hdl/alignAdder.sv
hdl/normalizer.sv
hdl/rounder.sv
hdl/fmaControl.sv
hdl/fma16.sv
tb/clockGen.sv
tb/fma16_sva.sv
tb/fma16Tb.sv

// ==== tb/clockGen.sv ====
`timescale 1ns/100ps
//======================================
// Testbench clock and reset generator
//======================================
module clockGen (
    output logic clk,
    output logic rstN
);
    localparam int resetCycles = 5;

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule

// ==== tb/fma16Tb.sv ====
`timescale 1ns/100ps
//======================================
// FMA testbench, vectors from a file
//======================================
module fma16Tb;
    import fmaPkg::*;

    localparam int resetTimeout = 50;
    localparam int maxLines     = 500;

    logic        clk, rstN;
    halfT        operandA, operandB, operandC;
    logic        mul, add;
    roundModeT   roundMode;
    halfT        result;
    logic [3:0]  flags;

    int          fd;
    int          vectorCount;
    int          errorCount;
    int          timeoutCount;
    int          fileErrors;
    logic [15:0] vecA, vecB, vecC, vecResult;
    logic [3:0]  vecMul, vecAdd, vecMode, vecFlags;

    clockGen u_clock (.clk, .rstN);

    fma16 u_dut (
        .clk, .rstN, .operandA, .operandB, .operandC, .mul, .add, .roundMode,
        .result, .flags
    );

    task automatic waitForReset();
        int cycles;
        cycles = 0;
        while (rstN !== 1'b1 && cycles < resetTimeout) begin
            @(negedge clk);
            cycles++;
        end
        if (rstN !== 1'b1) begin
            timeoutCount++;
            $display("Timeout: reset was not released within %0d cycles", resetTimeout);
        end
    endtask

    // One operation per call, result checked one cycle after capture
    task automatic applyVector();
        @(posedge clk);
        operandA  <= vecA;
        operandB  <= vecB;
        operandC  <= vecC;
        mul       <= vecMul[0];
        add       <= vecAdd[0];
        roundMode <= roundModeT'(vecMode[1:0]);
        @(posedge clk);
        @(negedge clk);
        vectorCount++;
        if (result !== vecResult) begin
            errorCount++;
            $display("** Error: vector %0d (A=0x%h B=0x%h C=0x%h) result = 0x%h, expected 0x%h",
                     vectorCount, vecA, vecB, vecC, result, vecResult);
        end
        if (flags !== vecFlags) begin
            errorCount++;
            $display("** Error: vector %0d (A=0x%h B=0x%h C=0x%h) flags = 0x%h, expected 0x%h",
                     vectorCount, vecA, vecB, vecC, flags, vecFlags);
        end
    endtask

    task automatic readVectors();
        int    lineCount;
        int    fields;
        int    got;
        string lineText;
        lineCount = 0;
        while (!$feof(fd) && lineCount < maxLines) begin
            lineCount++;
            lineText = "";
            got = $fgets(lineText, fd);
            if (got != 0) begin
                fields = $sscanf(lineText, "%h %h %h %h %h %h %h %h", vecA, vecB, vecC,
                                 vecMul, vecAdd, vecMode, vecResult, vecFlags);
                // Comment and blank lines parse no field
                if (fields == 8) begin
                    applyVector();
                end else if (fields > 0) begin
                    fileErrors++;
                    $display("Line %0d of the vector file has %0d fields instead of 8",
                             lineCount, fields);
                end
            end
        end
        if (!$feof(fd)) begin
            timeoutCount++;
            $display("Timeout: vector file did not end within %0d lines", maxLines);
        end
    endtask

    initial begin
        // A nonzero product held through reset, so only the clear zeroes the output
        operandA     = 16'h4000;
        operandB     = 16'h4200;
        operandC     = '0;
        mul          = 1'b1;
        add          = 1'b0;
        roundMode    = rz;
        vectorCount  = 0;
        errorCount   = 0;
        timeoutCount = 0;
        fileErrors   = 0;
        waitForReset();
        if (timeoutCount == 0) begin
            if (result !== '0) begin
                errorCount++;
                $display("** Error: result after reset = 0x%h, expected 0x0000", result);
            end
            if (flags !== '0) begin
                errorCount++;
                $display("** Error: flags after reset = 0x%h, expected 0x0", flags);
            end
            fd = $fopen("tb/fma16_testdata.txt", "r");
            if (fd == 0) begin
                fileErrors++;
                $display("Could not open the vector file tb/fma16_testdata.txt");
            end else begin
                readVectors();
                $fclose(fd);
                if (vectorCount == 0) begin
                    fileErrors++;
                    $display("The vector file held no usable vectors");
                end
            end
        end
        $display("Summary: %0d vectors, %0d value errors, %0d timeouts, %0d file errors",
                 vectorCount, errorCount, timeoutCount, fileErrors);
        if (errorCount == 0 && timeoutCount == 0 && fileErrors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== tb/fma16_sva.sv ====
`timescale 1ns/100ps
//======================================
// Output assertions bound to the FMA top
//======================================
module fma16Sva (
    input logic         clk,
    input logic         rstN,
    input fmaPkg::halfT result,
    input logic [3:0]   flags
);
    import fmaPkg::*;

    // No subnormal support, so underflow never rises
    underflowLow: assert property (@(posedge clk) disable iff (!rstN)
        !flags[flagUnderflow])
        else $error("Underflow flag was set");

    resetClears: assert property (@(posedge clk)
        !rstN |=> (result == '0 && flags == '0))
        else $error("Result or flags not cleared after a reset cycle");

    // Every invalid operation returns the quiet NaN
    invalidGivesNaN: assert property (@(posedge clk) disable iff (!rstN)
        flags[flagInvalid] |-> (result == canonicalNaN))
        else $error("Invalid flag raised without the canonical NaN result");

endmodule

bind fma16 fma16Sva u_sva (.clk, .rstN, .result, .flags);

// ==== tb/fma16_testdata.txt ====
// Columns in hex: A B C mul add roundMode expectedResult expectedFlags
// Flags: bit 3 invalid, bit 2 overflow, bit 1 underflow, bit 0 inexact
4000 4200 0000 1 0 1 4600 0
3C00 0000 3C00 0 1 0 4000 0
4000 4200 3C00 1 1 0 4700 0
4200 0000 C000 0 1 0 3C00 0
C000 4200 3C00 1 1 1 C500 0
3C01 3C01 3C00 1 1 0 4001 1
3C00 0000 1000 0 1 0 3C00 1
3C01 3C01 BC00 1 1 0 1800 1
3C00 3C00 C000 1 1 0 BC00 0
3C00 3C00 BC00 1 1 0 0000 0
3C00 3C00 BC00 1 1 2 8000 0
7800 7800 0000 1 0 0 7BFF 5
7800 7800 0000 1 0 1 7C00 5
7800 7800 0000 1 0 2 7C00 5
7800 7800 0000 1 0 3 7C00 5
7BFF 4000 0000 1 0 0 7BFF 5
7BFF 4000 0000 1 0 3 7C00 5
0000 7C00 3C00 1 1 0 7E00 8
7C00 3C00 FC00 1 1 0 7E00 8
7E00 3C00 3C00 1 1 0 7E00 0
3C00 7C01 0000 1 0 0 7E00 8
3C00 3C00 FD00 1 1 0 7E00 8
4000 4000 FC00 1 1 0 FC00 0
4000 7C00 3C00 1 1 0 7C00 0
